// File: common/board_pkg.sv
`default_nettype none

package board_pkg;

    localparam int w_count  = 16;
    localparam int w_colour = 4;
    localparam int w_seg    = 8;

    typedef logic [w_count  - 1:0] count_t;
    typedef logic [w_colour - 1:0] colour_t;

    // one axis of the VGA frame, in pixels or lines
    typedef struct packed {
        int unsigned active;
        int unsigned front;
        int unsigned sync;
        int unsigned back;
    } vga_geom_t;

    function automatic int unsigned geom_total(vga_geom_t g);
        return g.active + g.front + g.sync + g.back;
    endfunction

    function automatic int unsigned geom_sync_start(vga_geom_t g);
        return g.active + g.front;
    endfunction

    // standard hex font, abcdefgh with a in the msb, dot always off
    function automatic logic [w_seg - 1:0] hex_segments(logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/vga_if.sv
`default_nettype none

// pixel timing from vga_timing to vga_pattern
interface vga_if #(
    parameter int w_x = 10,
    parameter int w_y = 10
);

    logic             pixel_en;
    logic [w_x - 1:0] x;
    logic [w_y - 1:0] y;
    logic             display_on;

    // active low, as on the connector
    logic             hsync;
    logic             vsync;

    modport timing (
        output pixel_en,
        output x,
        output y,
        output display_on,
        output hsync,
        output vsync
    );

    modport pattern (
        input pixel_en,
        input x,
        input y,
        input display_on,
        input hsync,
        input vsync
    );

endinterface

`default_nettype wire

// File: src/key_counter.sv
`default_nettype none

module key_counter #(
    parameter int w_key = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [w_key - 1:0] key,
    output board_pkg::count_t count
);

    import board_pkg::*;

    logic [w_key - 1:0] key_s1;
    logic [w_key - 1:0] key_s2;
    logic [w_key - 1:0] key_q;
    logic [w_key - 1:0] press;
    logic               do_clear;
    logic               do_up;
    logic               do_down;

    // two-flop sync, then edge register
    always_ff @(posedge clk) begin
        if (reset) begin
            key_s1 <= '0;
            key_s2 <= '0;
            key_q  <= '0;
        end else begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_q  <= key_s2;
        end
    end

    assign press = key_s2 & ~key_q;

    // clear beats up, up beats down
    assign do_clear = press[2];
    assign do_up    = press[0] & ~press[2];
    assign do_down  = press[1] & ~press[0] & ~press[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (do_clear) begin
            count <= '0;
        end else if (do_up) begin
            count <= count + count_t'(1);
        end else if (do_down) begin
            count <= count - count_t'(1);
        end
    end

    // count moves only after a press, by one step or to zero
    a_one_action : assert property (@(posedge clk) disable iff (reset)
        (count != $past(count)) |-> ($past(|press)
            && ((count == '0)
                || (count == $past(count) + count_t'(1))
                || (count == $past(count) - count_t'(1)))));

endmodule

`default_nettype wire

// File: seven_seg/seven_seg_display.sv
`default_nettype none

module seven_seg_display #(
    parameter int clk_mhz = 50,
    parameter int w_digit = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  board_pkg::count_t             count,
    output logic [board_pkg::w_seg - 1:0] abcdefgh,
    output logic [w_digit - 1:0]          digit
);

    import board_pkg::*;

    // each digit is lit for 100 us
    localparam int refresh = clk_mhz * 100;
    localparam int w_div   = $clog2(refresh);
    localparam int w_idx   = (w_digit > 1) ? $clog2(w_digit) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               step;
    logic [w_idx - 1:0] idx;
    logic [w_idx - 1:0] idx_next;
    count_t             shifted;
    logic [3:0]         nibble;

    assign step = (div_cnt == w_div'(refresh - 1));

    always_ff @(posedge clk) begin
        if (reset || step) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign idx_next = (idx == w_idx'(w_digit - 1)) ? '0 : idx + 1'b1;

    // digits above the counter width shift out to zero
    assign shifted = count >> (4 * idx_next);

    always_ff @(posedge clk) begin
        if (reset) begin
            idx    <= '0;
            digit  <= w_digit'(1);
            nibble <= 4'h0;
        end else if (step) begin
            idx    <= idx_next;
            // select rotates alongside the index
            digit  <= (digit << 1) | w_digit'(digit[w_digit - 1]);
            nibble <= shifted[3:0];
        end
    end

    assign abcdefgh = hex_segments(nibble);

    a_digit_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot(digit) && digit[idx]);

endmodule

`default_nettype wire

// File: vga/vga_timing.sv
`default_nettype none

module vga_timing #(
    parameter int clk_per_pixel = 2,
    parameter int h_active      = 640,
    parameter int h_front       = 16,
    parameter int h_sync        = 96,
    parameter int h_back        = 48,
    parameter int v_active      = 480,
    parameter int v_front       = 10,
    parameter int v_sync        = 2,
    parameter int v_back        = 33
) (
    input  logic   clk,
    input  logic   reset,
    vga_if.timing  vga
);

    import board_pkg::*;

    localparam vga_geom_t h_geom = '{h_active, h_front, h_sync, h_back};
    localparam vga_geom_t v_geom = '{v_active, v_front, v_sync, v_back};

    localparam int h_total  = geom_total(h_geom);
    localparam int v_total  = geom_total(v_geom);
    localparam int hs_start = geom_sync_start(h_geom);
    localparam int vs_start = geom_sync_start(v_geom);
    localparam int w_x      = $clog2(h_total);
    localparam int w_y      = $clog2(v_total);
    localparam int w_pix    = (clk_per_pixel > 1) ? $clog2(clk_per_pixel) : 1;

    logic [w_pix - 1:0] pix_cnt;
    logic               pix_last;
    logic [w_x - 1:0]   h_cnt;
    logic [w_y - 1:0]   v_cnt;
    logic               h_last;
    logic               v_last;

    // ======================================================================
    // pixel enable and frame counters
    // ======================================================================

    assign pix_last = (pix_cnt == w_pix'(clk_per_pixel - 1));
    assign h_last   = (int'(h_cnt) == h_total - 1);
    assign v_last   = (int'(v_cnt) == v_total - 1);

    always_ff @(posedge clk) begin
        if (reset || pix_last) begin
            pix_cnt <= '0;
        end else begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_last) begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    assign vga.pixel_en   = pix_last;
    assign vga.x          = h_cnt;
    assign vga.y          = v_cnt;
    assign vga.display_on = (int'(h_cnt) < h_active) && (int'(v_cnt) < v_active);

    // sync pulses sit between the front and back porches
    assign vga.hsync = !((int'(h_cnt) >= hs_start) && (int'(h_cnt) < hs_start + h_sync));
    assign vga.vsync = !((int'(v_cnt) >= vs_start) && (int'(v_cnt) < vs_start + v_sync));

    // counters never leave the frame
    a_counters_in_frame : assert property (@(posedge clk) disable iff (reset)
        (int'(h_cnt) < h_total) && (int'(v_cnt) < v_total));

endmodule

`default_nettype wire

// File: vga/vga_pattern.sv
`default_nettype none

module vga_pattern #(
    parameter int h_active = 640
) (
    input  logic               clk,
    input  logic               reset,
    input  board_pkg::count_t  count,
    vga_if.pattern             vga,
    output board_pkg::colour_t red,
    output board_pkg::colour_t green,
    output board_pkg::colour_t blue
);

    // eight bars across the active line
    localparam int bar_w = (h_active >= 8) ? h_active / 8 : 1;

    logic [2:0] bar;

    // counter slides the bars sideways, wrapping at eight
    assign bar = 3'(int'(vga.x) / bar_w) + count[2:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (vga.display_on) begin
            red   <= bar[0] ? '1 : '0;
            green <= bar[1] ? '1 : '0;
            blue  <= bar[2] ? '1 : '0;
        end else begin
            // blanking
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/lab_top.sv
`default_nettype none

module lab_top #(
    parameter int clk_mhz       = 50,
    parameter int w_key         = 3,
    parameter int w_led         = 4,
    parameter int w_digit       = 8,
    parameter int clk_per_pixel = 2,
    parameter int h_active      = 640,
    parameter int h_front       = 16,
    parameter int h_sync        = 96,
    parameter int h_back        = 48,
    parameter int v_active      = 480,
    parameter int v_front       = 10,
    parameter int v_sync        = 2,
    parameter int v_back        = 33
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [w_key - 1:0]            key,
    output logic [w_led - 1:0]            led,
    output logic [board_pkg::w_seg - 1:0] abcdefgh,
    output logic [w_digit - 1:0]          digit,
    output logic                          hsync,
    output logic                          vsync,
    output board_pkg::colour_t            red,
    output board_pkg::colour_t            green,
    output board_pkg::colour_t            blue
);

    import board_pkg::*;

    localparam vga_geom_t h_geom = '{h_active, h_front, h_sync, h_back};
    localparam vga_geom_t v_geom = '{v_active, v_front, v_sync, v_back};
    localparam int w_x = $clog2(geom_total(h_geom));
    localparam int w_y = $clog2(geom_total(v_geom));

    count_t count;

    vga_if #(.w_x(w_x), .w_y(w_y)) vga_bus ();

    // ======================================================================
    // counter and its two displays
    // ======================================================================

    key_counter #(.w_key(w_key)) key_counter_i (
        .clk   (clk),
        .reset (reset),
        .key   (key),
        .count (count)
    );

    assign led = count[w_led - 1:0];

    seven_seg_display #(
        .clk_mhz (clk_mhz),
        .w_digit (w_digit)
    ) seven_seg_i (
        .clk      (clk),
        .reset    (reset),
        .count    (count),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ======================================================================
    // vga
    // ======================================================================

    vga_timing #(
        .clk_per_pixel (clk_per_pixel),
        .h_active      (h_active),
        .h_front       (h_front),
        .h_sync        (h_sync),
        .h_back        (h_back),
        .v_active      (v_active),
        .v_front       (v_front),
        .v_sync        (v_sync),
        .v_back        (v_back)
    ) vga_timing_i (
        .clk   (clk),
        .reset (reset),
        .vga   (vga_bus.timing)
    );

    vga_pattern #(.h_active(h_active)) vga_pattern_i (
        .clk   (clk),
        .reset (reset),
        .count (count),
        .vga   (vga_bus.pattern),
        .red   (red),
        .green (green),
        .blue  (blue)
    );

    // sync follows the colour register by one stage
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= vga_bus.hsync;
            vsync <= vga_bus.vsync;
        end
    end

endmodule

`default_nettype wire

// File: src/board_specific_top.sv
`default_nettype none

module board_specific_top #(
    parameter int clk_mhz       = 50,
    parameter int w_key         = 3,
    parameter int w_led         = 4,
    parameter int w_digit       = 8,
    parameter int clk_per_pixel = 2,
    parameter int h_active      = 640,
    parameter int h_front       = 16,
    parameter int h_sync        = 96,
    parameter int h_back        = 48,
    parameter int v_active      = 480,
    parameter int v_front       = 10,
    parameter int v_sync        = 2,
    parameter int v_back        = 33
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [w_key - 1:0]           key,
    output logic [w_led - 1:0]           led,

    output logic [board_pkg::w_seg - 1:0] seg_data,
    output logic [w_digit - 1:0]         seg_sel,

    output logic                         vga_hs,
    output logic                         vga_vs,
    output logic [4:0]                   vga_r,
    output logic [5:0]                   vga_g,
    output logic [4:0]                   vga_b
);

    import board_pkg::*;

    logic [w_key - 1:0]   key_act;
    logic [w_seg - 1:0]   abcdefgh;
    logic [w_digit - 1:0] digit;
    colour_t              red;
    colour_t              green;
    colour_t              blue;

    // keys pull low when pressed
    assign key_act = ~key;

    lab_top #(
        .clk_mhz       (clk_mhz),
        .w_key         (w_key),
        .w_led         (w_led),
        .w_digit       (w_digit),
        .clk_per_pixel (clk_per_pixel),
        .h_active      (h_active),
        .h_front       (h_front),
        .h_sync        (h_sync),
        .h_back        (h_back),
        .v_active      (v_active),
        .v_front       (v_front),
        .v_sync        (v_sync),
        .v_back        (v_back)
    ) lab_top_i (
        .clk      (clk),
        .reset    (reset),
        .key      (key_act),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hsync    (vga_hs),
        .vsync    (vga_vs),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    // common anode display
    assign seg_data = ~abcdefgh;
    assign seg_sel  = ~digit;

    // 4-bit colours into the 5/6/5 resistor DAC
    assign vga_r = {red, 1'b0};
    assign vga_g = {green, 2'b00};
    assign vga_b = {blue, 1'b0};

endmodule

`default_nettype wire

// File: bench/board_checker.sv
`default_nettype none

module board_checker #(
    parameter int clk_mhz       = 1,
    parameter int w_key         = 3,
    parameter int w_led         = 4,
    parameter int w_digit       = 8,
    parameter int clk_per_pixel = 2,
    parameter int h_active      = 16,
    parameter int h_front       = 2,
    parameter int h_sync        = 4,
    parameter int h_back        = 2,
    parameter int v_active      = 4,
    parameter int v_front       = 1,
    parameter int v_sync        = 1,
    parameter int v_back        = 1
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [w_key - 1:0]            key,
    input  logic [w_led - 1:0]            led,
    input  logic [board_pkg::w_seg - 1:0] seg_data,
    input  logic [w_digit - 1:0]          seg_sel,
    input  logic                          vga_hs,
    input  logic                          vga_vs,
    input  logic [4:0]                    vga_r,
    input  logic [5:0]                    vga_g,
    input  logic [4:0]                    vga_b,
    input  board_pkg::count_t             exp_count,
    input  logic                          count_stable,
    output logic                          sweep_done,
    output int                            reset_errs,
    output int                            count_errs,
    output int                            display_errs,
    output int                            timing_errs,
    output int                            pattern_errs,
    output int                            timing_seen,
    output int                            pattern_seen
);

    import board_pkg::*;

    localparam int refresh      = clk_mhz * 100;
    localparam int line_cycles  = (h_active + h_front + h_sync + h_back) * clk_per_pixel;
    localparam int frame_cycles = line_cycles * (v_active + v_front + v_sync + v_back);
    localparam int hs_low       = h_sync * clk_per_pixel;
    localparam int vs_low       = v_sync * line_cycles;
    localparam int key_latency  = 3;
    localparam logic [w_digit - 1:0] sel_digit0 = ~w_digit'(1);

    logic                 reset_q;
    logic [w_key - 1:0]   key_prev;
    int                   led_wait;
    logic [w_digit - 1:0] sel_prev;
    logic [w_digit - 1:0] sel_act;
    int                   changes;
    int                   hold;
    int                   idx;
    int                   h_cyc;
    int                   v_cyc;
    logic                 h_fell;
    logic                 v_fell;
    logic                 hs_prev;
    logic                 vs_prev;
    logic                 in_frame;
    int                   line_k;
    int                   pix_wait;
    logic [2:0]           bar;

    initial begin
        reset_errs   = 0;
        count_errs   = 0;
        display_errs = 0;
        timing_errs  = 0;
        pattern_errs = 0;
        timing_seen  = 0;
        pattern_seen = 0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want, inout int errs);
        if (got !== want) begin
            $display("error: t=%0t %s expected %h got %h", $time, name, want, got);
            errs++;
        end
    endtask

    // pin pattern of a common-anode digit
    function automatic logic [7:0] seg_pins(logic [3:0] nibble);
        return ~hex_segments(nibble);
    endfunction

    function automatic logic [3:0] nibble_at(count_t value, int digit);
        if (digit >= 4) begin
            return 4'h0;
        end
        return value[4 * digit +: 4];
    endfunction

    function automatic int digit_index(logic [w_digit - 1:0] sel);
        int found;
        found = 0;
        for (int i = 0; i < w_digit; i++) begin
            if (!sel[i]) begin
                found = i;
            end
        end
        return found;
    endfunction

    always @(posedge clk) begin
        reset_q <= reset;
    end

    // ======================================================================
    // reset state and key counting
    // ======================================================================

    always @(negedge clk) begin
        if (reset_q) begin
            compare_value("led", led, 0, reset_errs);
            compare_value("seg_sel", seg_sel, sel_digit0, reset_errs);
            compare_value("seg_data", seg_data, seg_pins(4'h0), reset_errs);
            compare_value("vga_hs", vga_hs, 1, reset_errs);
            compare_value("vga_vs", vga_vs, 1, reset_errs);
            compare_value("vga colour", {vga_r, vga_g, vga_b}, 0, reset_errs);
        end
    end

    always @(negedge clk) begin
        if (reset_q) begin
            led_wait = 0;
            key_prev = key;
        end else begin
            if (led_wait > 0) begin
                led_wait--;
                if (led_wait == 0) begin
                    compare_value("led", led, exp_count[w_led - 1:0], count_errs);
                end
            end
            // count moves three edges after the pin
            if (key !== key_prev) begin
                led_wait = key_latency;
            end
            key_prev = key;
        end
    end

    // ======================================================================
    // display sweep
    // ======================================================================

    assign sweep_done = (changes >= w_digit);

    always @(negedge clk) begin
        if (reset_q || !count_stable) begin
            changes  = 0;
            hold     = 0;
            sel_prev = seg_sel;
        end else begin
            hold++;
            sel_act = ~seg_sel;
            if (!$onehot(sel_act)) begin
                $display("error: t=%0t seg_sel %b does not select exactly one digit",
                         $time, seg_sel);
                display_errs++;
            end else if (seg_sel !== sel_prev) begin
                idx = digit_index(seg_sel);
                compare_value("digit index", idx, (digit_index(sel_prev) + 1) % w_digit,
                              display_errs);
                compare_value("seg_data", seg_data, seg_pins(nibble_at(exp_count, idx)),
                              display_errs);
                if (changes > 0) begin
                    compare_value("digit hold cycles", hold, refresh, display_errs);
                end
                changes++;
                hold = 0;
            end
            sel_prev = seg_sel;
        end
    end

    // ======================================================================
    // vga sync timing and colours
    // ======================================================================

    always @(negedge clk) begin
        if (reset_q) begin
            h_cyc    = 0;
            v_cyc    = 0;
            h_fell   = 1'b0;
            v_fell   = 1'b0;
            hs_prev  = 1'b1;
            vs_prev  = 1'b1;
            in_frame = 1'b0;
            line_k   = 0;
            pix_wait = 0;
        end else begin
            h_cyc++;
            v_cyc++;
            if (hs_prev && !vga_hs) begin
                if (h_fell) begin
                    compare_value("hsync period", h_cyc, line_cycles, timing_errs);
                    timing_seen++;
                end
                h_fell = 1'b1;
                h_cyc  = 0;
            end
            if (!hs_prev && vga_hs && h_fell) begin
                compare_value("hsync low width", h_cyc, hs_low, timing_errs);
            end
            if (vs_prev && !vga_vs) begin
                if (v_fell) begin
                    compare_value("vsync period", v_cyc, frame_cycles, timing_errs);
                end
                v_fell = 1'b1;
                v_cyc  = 0;
            end
            if (!vs_prev && vga_vs && v_fell) begin
                compare_value("vsync low width", v_cyc, vs_low, timing_errs);
            end

            if (!vga_hs || !vga_vs) begin
                compare_value("colour in sync", {vga_r, vga_g, vga_b}, 0, pattern_errs);
            end
            compare_value("colour pad bits", {vga_r[0], vga_g[1:0], vga_b[0]}, 0,
                          pattern_errs);

            if (pix_wait > 0) begin
                pix_wait--;
                if (pix_wait == 0 && count_stable) begin
                    // x is 0 here so only the count picks the bar
                    bar = exp_count[2:0];
                    compare_value("vga_r", vga_r, {{4{bar[0]}}, 1'b0}, pattern_errs);
                    compare_value("vga_g", vga_g, {{4{bar[1]}}, 2'b00}, pattern_errs);
                    compare_value("vga_b", vga_b, {{4{bar[2]}}, 1'b0}, pattern_errs);
                    pattern_seen++;
                end
            end

            // lines are counted from the end of vsync
            if (!vs_prev && vga_vs) begin
                in_frame = 1'b1;
                line_k   = 0;
            end
            if (!hs_prev && vga_hs && in_frame) begin
                if (line_k >= v_back - 1 && line_k < v_back + v_active - 1) begin
                    pix_wait = h_back * clk_per_pixel;
                end
                line_k++;
            end
            hs_prev = vga_hs;
            vs_prev = vga_vs;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_board.sv
`default_nettype none

module tb_board;

    import board_pkg::*;

    localparam int clk_mhz       = 1;
    localparam int w_key         = 3;
    localparam int w_led         = 4;
    localparam int w_digit       = 8;
    localparam int clk_per_pixel = 2;
    localparam int h_active      = 16;
    localparam int h_front       = 2;
    localparam int h_sync        = 4;
    localparam int h_back        = 2;
    localparam int v_active      = 4;
    localparam int v_front       = 1;
    localparam int v_sync        = 1;
    localparam int v_back        = 1;

    localparam int half_period  = 20;
    localparam int drive_delay  = 5;
    localparam int reset_cycles = 8;
    localparam int frame_cycles = (h_active + h_front + h_sync + h_back) * clk_per_pixel
                                  * (v_active + v_front + v_sync + v_back);
    localparam int sweep_cycles = w_digit * clk_mhz * 100;
    localparam int margin       = 200;
    localparam int n_rows       = 16;

    // keys active high here, bit 0 up, bit 1 down, bit 2 clear
    typedef struct packed {
        logic [w_key - 1:0] keys;
        int                 press;
        int                 idle;
        count_t             count;
    } row_t;

    row_t rows [n_rows] = '{
        '{3'b001,  3, 6, 16'h0001},
        '{3'b001,  4, 6, 16'h0002},
        '{3'b001,  3, 8, 16'h0003},
        '{3'b010,  3, 6, 16'h0002},
        '{3'b010,  5, 6, 16'h0001},
        '{3'b010,  3, 6, 16'h0000},
        // below zero wraps
        '{3'b010,  3, 6, 16'hffff},
        '{3'b010,  3, 6, 16'hfffe},
        // held key acts once
        '{3'b001, 40, 6, 16'hffff},
        '{3'b001,  3, 6, 16'h0000},
        '{3'b011,  3, 6, 16'h0001},
        '{3'b001,  3, 6, 16'h0002},
        '{3'b111,  3, 6, 16'h0000},
        '{3'b110,  3, 6, 16'h0000},
        '{3'b010,  3, 6, 16'hffff},
        '{3'b010,  3, 7, 16'hfffe}
    };

    logic                 clk;
    logic                 reset;
    logic [w_key - 1:0]   key;
    logic [w_led - 1:0]   led;
    logic [w_seg - 1:0]   seg_data;
    logic [w_digit - 1:0] seg_sel;
    logic                 vga_hs;
    logic                 vga_vs;
    logic [4:0]           vga_r;
    logic [5:0]           vga_g;
    logic [4:0]           vga_b;
    count_t               exp_count;
    logic                 count_stable;
    logic                 sweep_done;
    int                   reset_errs;
    int                   count_errs;
    int                   display_errs;
    int                   timing_errs;
    int                   pattern_errs;
    int                   timing_seen;
    int                   pattern_seen;
    int                   cycles;
    int                   limit;
    int                   tests_passed;
    int                   tests_failed;

    board_specific_top #(
        .clk_mhz (clk_mhz), .w_key (w_key), .w_led (w_led), .w_digit (w_digit),
        .clk_per_pixel (clk_per_pixel),
        .h_active (h_active), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
        .v_active (v_active), .v_front (v_front), .v_sync (v_sync), .v_back (v_back)
    ) dut_i (
        .clk (clk), .reset (reset), .key (key), .led (led),
        .seg_data (seg_data), .seg_sel (seg_sel), .vga_hs (vga_hs), .vga_vs (vga_vs),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
    );

    board_checker #(
        .clk_mhz (clk_mhz), .w_key (w_key), .w_led (w_led), .w_digit (w_digit),
        .clk_per_pixel (clk_per_pixel),
        .h_active (h_active), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
        .v_active (v_active), .v_front (v_front), .v_sync (v_sync), .v_back (v_back)
    ) checker_i (
        .clk (clk), .reset (reset), .key (key), .led (led),
        .seg_data (seg_data), .seg_sel (seg_sel), .vga_hs (vga_hs), .vga_vs (vga_vs),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
        .exp_count (exp_count), .count_stable (count_stable), .sweep_done (sweep_done),
        .reset_errs (reset_errs), .count_errs (count_errs), .display_errs (display_errs),
        .timing_errs (timing_errs), .pattern_errs (pattern_errs),
        .timing_seen (timing_seen), .pattern_seen (pattern_seen)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // every press, every gap and one display sweep per row, plus two frames
    function automatic int run_limit();
        int total;
        total = reset_cycles + 2 * frame_cycles + n_rows * sweep_cycles + margin;
        for (int i = 0; i < n_rows; i++) begin
            total += rows[i].press + rows[i].idle;
        end
        return total;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic report_test(input string name, input int errs, input int seen);
        if (seen == 0) begin
            $display("test %s: failed, the check never got to run", name);
            tests_failed++;
        end else if (errs != 0) begin
            $display("test %s: failed with %0d errors", name, errs);
            tests_failed++;
        end else begin
            $display("test %s: ok", name);
            tests_passed++;
        end
    endtask

    initial begin
        cycles       = 0;
        limit        = run_limit();
        tests_passed = 0;
        tests_failed = 0;
        reset        = 1'b1;
        key          = '1;
        exp_count    = '0;
        count_stable = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        @(posedge clk);
        report_test("reset state", reset_errs, 1);

        // ==================================================================
        // key rows, each followed by one display sweep
        // ==================================================================
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #drive_delay;
            key       = ~rows[i].keys;
            exp_count = rows[i].count;
            repeat (rows[i].press) @(posedge clk);
            #drive_delay;
            key = '1;
            repeat (rows[i].idle) @(posedge clk);
            #drive_delay;
            count_stable = 1'b1;
            while (!sweep_done) @(posedge clk);
            #drive_delay;
            count_stable = 1'b0;
        end

        report_test("counting", count_errs, 1);
        report_test("display", display_errs, 1);
        report_test("vga timing", timing_errs, timing_seen);
        report_test("pattern and blanking", pattern_errs, pattern_seen);

        $display("tests: %0d passed, %0d failed, %0d errors in total", tests_passed,
                 tests_failed,
                 reset_errs + count_errs + display_errs + timing_errs + pattern_errs);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/board_pkg.sv
common/vga_if.sv
src/key_counter.sv
seven_seg/seven_seg_display.sv
vga/vga_timing.sv
vga/vga_pattern.sv
src/lab_top.sv
src/board_specific_top.sv
bench/board_checker.sv
bench/tb_board.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_board -f src.f &&
./obj_dir/Vtb_board | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
